// ==== compile.f ====
src/decode_pkg.sv
src/decode_if.sv
src/prefix_decode.sv
src/opcode_decode.sv
src/modrm_decode.sv
src/disp_imm_length.sv
src/eip_control.sv
src/decode_top.sv
verification/tb_decode.sv

// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert -j 0
RTL_TOP    = decode_top
TB_TOP     = tb_decode
FILELIST   = compile.f
PASS_TEXT  = TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) -o $(TB_TOP)
	./obj_dir/$(TB_TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir

// ==== verification/tb_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode;
    import decode_pkg::*;

    localparam int NUM_TESTS      = 600;
    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = 3 * NUM_TESTS + 200;  // 2000, ample margin

    localparam logic [7:0] PREFIXES [8] = '{PFX_REP, PFX_OPSIZE, PFX_ES, PFX_CS,
                                            PFX_SS, PFX_DS, PFX_FS, PFX_GS};

    logic         clk;
    logic         rst_n;
    logic         valid_in;
    logic [127:0] packet_in;
    logic         queue_full_stall;
    logic         is_init;
    logic [31:0]  init_eip;
    logic         is_resteer;
    logic [31:0]  wb_eip;
    logic         is_br_taken;
    logic [31:0]  bp_eip;

    logic        valid_out;
    logic        stall_out;
    logic        rep_out;
    logic        opsize_ovr_out;
    logic        seg_valid_out;
    logic [2:0]  seg_sel_out;
    logic [2:0]  reg_field_out;
    logic [2:0]  base_reg_out;
    logic [2:0]  index_reg_out;
    logic [1:0]  scale_out;
    logic        use_base_out;
    logic        use_index_out;
    logic        is_br_out;
    logic [31:0] disp_out;
    logic [31:0] imm_out;
    logic [7:0]  d_length;
    logic [31:0] eip_out;
    logic [31:0] latched_eip_out;

    decode_top u_decode_top (.*);

    ////////////////////////////////////////////////////////////////////////////
    // reference model, walks the packet byte by byte
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic is_prefix(input logic [7:0] b);
        return b inside {PFX_REP, PFX_OPSIZE, PFX_ES, PFX_CS, PFX_SS, PFX_DS, PFX_FS, PFX_GS};
    endfunction

    function automatic logic [2:0] seg_index(input logic [7:0] b);
        case (b)
            PFX_CS:  return 3'd1;
            PFX_SS:  return 3'd2;
            PFX_DS:  return 3'd3;
            PFX_FS:  return 3'd4;
            PFX_GS:  return 3'd5;
            default: return 3'd0;  // ES
        endcase
    endfunction

    function automatic logic in_table(input logic [7:0] op);
        return op inside {8'h01, 8'h03, 8'h05, 8'h0F, 8'h81, 8'h83, 8'h89, 8'h8B,
                          8'h90, [8'hB8:8'hBF], 8'hC3, 8'hE9, 8'hEB};
    endfunction

    // little endian read, sign extended from its size
    function automatic logic [31:0] read_field(input logic [7:0] b [16], input int pos,
                                               input int size);
        logic [31:0] v;
        v = '0;
        for (int k = size - 1; k >= 0; k--) begin
            v = {v[23:0], b[pos + k]};
        end
        case (size)
            1:       return {{24{v[7]}}, v[7:0]};
            2:       return {{16{v[15]}}, v[15:0]};
            4:       return v;
            default: return '0;
        endcase
    endfunction

    function automatic void ref_decode(input logic [127:0] pkt, output logic [5:0] pfx,
                                       output logic [12:0] addr, output logic [31:0] disp,
                                       output logic [31:0] imm, output logic br,
                                       output logic [7:0] len);
        logic [7:0] b [16];
        logic       rep;
        logic       opsz;
        logic       segv;
        logic [2:0] seg;
        logic       has_m;
        modrm_sib_u m;
        modrm_sib_u s;
        logic [2:0] base;
        logic [2:0] idx;
        logic [1:0] scl;
        logic       ub;
        logic       ui;
        int         p;
        int         isz;
        int         dsz;
        int         iz;
        for (int i = 0; i < 16; i++) begin
            b[i] = pkt[127 - 8*i -: 8];  // byte 0 on top
        end
        {rep, opsz, segv, seg, has_m, base, idx, scl, ub, ui, br} = '0;
        p   = 0;
        isz = 0;
        dsz = 0;
        while (p < MAX_PREFIXES && is_prefix(b[p])) begin
            if (b[p] == PFX_REP) rep = 1'b1;
            else if (b[p] == PFX_OPSIZE) opsz = 1'b1;
            else begin
                segv = 1'b1;
                seg  = seg_index(b[p]);  // last segment prefix wins
            end
            p++;
        end
        iz = opsz ? 2 : 4;  // imm z
        if (b[p] == OPC_ESCAPE) begin
            if (b[p+1][7:4] == 4'h8) begin
                isz = iz;
                br  = 1'b1;
            end else if (b[p+1] == 8'hAF) has_m = 1'b1;
            p += 2;
        end else begin
            case (b[p])
                8'h01, 8'h03, 8'h89, 8'h8B: has_m = 1'b1;
                8'h05, 8'hB8, 8'hB9, 8'hBA, 8'hBB, 8'hBC, 8'hBD, 8'hBE, 8'hBF: isz = iz;
                8'h81: begin
                    has_m = 1'b1;
                    isz   = iz;
                end
                8'h83: begin
                    has_m = 1'b1;
                    isz   = 1;
                end
                8'hEB: begin
                    isz = 1;
                    br  = 1'b1;
                end
                8'hE9: begin
                    isz = iz;
                    br  = 1'b1;
                end
                default: isz = 0;  // one byte, nothing follows
            endcase
            p += 1;
        end
        m = b[p];
        s = b[p+1];
        if (has_m) begin
            p++;
            if (m.modrm.mod == 2'b11) begin
                base = m.modrm.rm;
                ub   = 1'b1;
            end else begin
                dsz = (m.modrm.mod == 2'b01) ? 1 : (m.modrm.mod == 2'b10) ? 4 : 0;
                if (m.modrm.rm == 3'd4) begin
                    p++;  // sib present
                    scl = s.sib.scale;
                    ui  = (s.sib.index != 3'd4);
                    idx = ui ? s.sib.index : 3'd0;
                    if (s.sib.base == 3'd5 && m.modrm.mod == 2'b00) dsz = 4;
                    else begin
                        base = s.sib.base;
                        ub   = 1'b1;
                    end
                end else if (m.modrm.mod == 2'b00 && m.modrm.rm == 3'd5) dsz = 4;
                else begin
                    base = m.modrm.rm;
                    ub   = 1'b1;
                end
            end
        end
        disp = read_field(b, p, dsz);
        p += dsz;
        imm  = read_field(b, p, isz);
        p += isz;
        len  = 8'(p);
        pfx  = {rep, opsz, segv, seg};
        addr = {(has_m ? m.modrm.reg_op : 3'd0), base, idx, scl, ub, ui};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // instruction generator
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [127:0] gen_instruction();
        logic [7:0]   b [16];
        logic [127:0] pkt;
        modrm_sib_u   m;
        modrm_sib_u   s;
        int           p;
        int           npfx;
        for (int i = 0; i < 16; i++) begin
            b[i] = 8'($urandom);  // filler, disp and imm bytes
        end
        npfx = int'($urandom % 4);
        for (p = 0; p < npfx; p++) begin
            b[p] = PREFIXES[3'($urandom)];
        end
        case ($urandom % 15)
            0:  b[p] = 8'h01;
            1:  b[p] = 8'h03;
            2:  b[p] = 8'h89;
            3:  b[p] = 8'h8B;
            4:  b[p] = 8'h05;
            5:  b[p] = 8'h81;
            6:  b[p] = 8'h83;
            7:  b[p] = 8'hB8 | 8'($urandom % 8);
            8:  b[p] = 8'h90;
            9:  b[p] = 8'hC3;
            10: b[p] = 8'hEB;
            11: b[p] = 8'hE9;
            12: b[p] = OPC_ESCAPE;
            13: b[p] = OPC_ESCAPE;
            default: begin
                while (is_prefix(b[p]) || in_table(b[p])) b[p] = 8'($urandom);
            end
        endcase
        if (b[p] == OPC_ESCAPE) begin
            b[p+1] = ($urandom % 2 == 0) ? 8'hAF : (8'h80 | 8'($urandom % 16));
            p++;
        end
        p++;
        m = 8'($urandom);
        if ($urandom % 3 == 0) m.modrm.rm = 3'd4;    // push toward sib
        if ($urandom % 4 == 0) m.modrm.mod = 2'b00;
        s = 8'($urandom);
        if ($urandom % 4 == 0) s.sib.base = 3'd5;
        if ($urandom % 4 == 0) s.sib.index = 3'd4;
        b[p]   = m;
        b[p+1] = s;
        for (int i = 0; i < 16; i++) begin
            pkt[127 - 8*i -: 8] = b[i];
        end
        return pkt;
    endfunction

    // expected values, straight from the inputs
    logic [5:0]  ref_pfx;
    logic [12:0] ref_addr;
    logic [31:0] ref_disp;
    logic [31:0] ref_imm;
    logic        ref_br;
    logic [7:0]  ref_len;
    logic        any_cf;
    logic [7:0]  exp_len;
    logic [31:0] exp_target;

    always_comb begin
        ref_decode(packet_in, ref_pfx, ref_addr, ref_disp, ref_imm, ref_br, ref_len);
    end

    assign any_cf     = is_init | is_resteer | is_br_taken;
    assign exp_len    = any_cf ? 8'd0 : ref_len;  // redirect zeroes length
    assign exp_target = is_init ? init_eip : is_resteer ? wb_eip : bp_eip;

    // previous cycle, for the pointer checks
    logic        prev_cf = 1'b0;
    logic        prev_load = 1'b0;
    logic        prev_stall = 1'b0;
    logic [31:0] prev_eip = '0;
    logic [31:0] prev_latched = '0;
    logic [31:0] prev_target = '0;

    always @(posedge clk) begin
        prev_cf      <= any_cf;
        prev_load    <= valid_in & ~queue_full_stall;
        prev_stall   <= queue_full_stall;
        prev_eip     <= eip_out;
        prev_latched <= latched_eip_out;
        prev_target  <= exp_target;
    end

    int cycles = 0;
    logic [2:0] redirect;

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("Mismatch %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
        $display("TEST RESULT: FAIL");
        $fatal(1, "decode check failed");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////
    a_prefix: assert property (@(posedge clk) disable iff (!rst_n)
        {rep_out, opsize_ovr_out, seg_valid_out, seg_sel_out} == ref_pfx)
        else report_mismatch("prefix", 32'($sampled(ref_pfx)), 32'($sampled(
            {rep_out, opsize_ovr_out, seg_valid_out, seg_sel_out})));
    a_length: assert property (@(posedge clk) disable iff (!rst_n) d_length == exp_len)
        else report_mismatch("length", 32'($sampled(exp_len)), 32'($sampled(d_length)));
    a_imm: assert property (@(posedge clk) disable iff (!rst_n) imm_out == ref_imm)
        else report_mismatch("imm", $sampled(ref_imm), $sampled(imm_out));
    a_branch: assert property (@(posedge clk) disable iff (!rst_n) is_br_out == ref_br)
        else report_mismatch("is_br", 32'($sampled(ref_br)), 32'($sampled(is_br_out)));
    a_addr: assert property (@(posedge clk) disable iff (!rst_n)
        {reg_field_out, base_reg_out, index_reg_out, scale_out, use_base_out,
         use_index_out} == ref_addr)
        else report_mismatch("addressing", 32'($sampled(ref_addr)), 32'($sampled(
            {reg_field_out, base_reg_out, index_reg_out, scale_out, use_base_out,
             use_index_out})));
    a_disp: assert property (@(posedge clk) disable iff (!rst_n) disp_out == ref_disp)
        else report_mismatch("disp", $sampled(ref_disp), $sampled(disp_out));
    a_eip_sum: assert property (@(posedge clk) disable iff (!rst_n)
        eip_out == latched_eip_out + 32'(exp_len))
        else report_mismatch("eip_sum", $sampled(latched_eip_out + 32'(exp_len)),
                             $sampled(eip_out));
    a_levels: assert property (@(posedge clk) disable iff (!rst_n)
        stall_out == queue_full_stall && valid_out == valid_in)
        else report_mismatch("levels", 32'($sampled({queue_full_stall, valid_in})),
                             32'($sampled({stall_out, valid_out})));
    a_advance: assert property (@(posedge clk) disable iff (!rst_n)
        (!prev_cf && prev_load) |-> latched_eip_out == prev_eip)
        else report_mismatch("advance", $sampled(prev_eip), $sampled(latched_eip_out));
    a_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (!prev_cf && prev_stall) |-> latched_eip_out == prev_latched)
        else report_mismatch("stall_hold", $sampled(prev_latched), $sampled(latched_eip_out));
    a_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        prev_cf |-> latched_eip_out == prev_target)
        else report_mismatch("redirect", $sampled(prev_target), $sampled(latched_eip_out));

    // runaway guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(29));
        rst_n            = 1'b0;
        valid_in         = 1'b0;
        packet_in        = '0;
        queue_full_stall = 1'b0;
        is_init          = 1'b0;
        init_eip         = '0;
        is_resteer       = 1'b0;
        wb_eip           = '0;
        is_br_taken      = 1'b0;
        bp_eip           = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        a_reset: assert (latched_eip_out == '0)
            else report_mismatch("reset_eip", 32'd0, latched_eip_out);
        repeat (NUM_TESTS) begin
            @(posedge clk);
            redirect = ($urandom % 5 == 0) ? 3'($urandom % 7 + 1) : 3'd0;
            packet_in        <= gen_instruction();
            valid_in         <= ($urandom % 4) != 0;
            queue_full_stall <= ($urandom % 4) == 0;  // stall about one in four
            {is_init, is_resteer, is_br_taken} <= redirect;
            init_eip         <= $urandom;
            wb_eip           <= $urandom;
            bp_eip           <= $urandom;
        end
        repeat (2) @(posedge clk);  // let the last checks fire
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  valid_in,
    input  logic [decode_pkg::PACKET_BYTES*8-1:0] packet_in,  // byte 0 in top bits
    input  logic                                  queue_full_stall,
    input  logic                                  is_init,
    input  logic [decode_pkg::ADDR_W-1:0]         init_eip,
    input  logic                                  is_resteer,
    input  logic [decode_pkg::ADDR_W-1:0]         wb_eip,
    input  logic                                  is_br_taken,
    input  logic [decode_pkg::ADDR_W-1:0]         bp_eip,
    output logic                                  valid_out,
    output logic                                  stall_out,
    output logic                                  rep_out,
    output logic                                  opsize_ovr_out,
    output logic                                  seg_valid_out,
    output logic [2:0]                            seg_sel_out,
    output logic [decode_pkg::REG_W-1:0]          reg_field_out,
    output logic [decode_pkg::REG_W-1:0]          base_reg_out,
    output logic [decode_pkg::REG_W-1:0]          index_reg_out,
    output logic [1:0]                            scale_out,
    output logic                                  use_base_out,
    output logic                                  use_index_out,
    output logic                                  is_br_out,
    output logic [decode_pkg::ADDR_W-1:0]         disp_out,
    output logic [decode_pkg::ADDR_W-1:0]         imm_out,
    output logic [decode_pkg::LEN_W-1:0]          d_length,
    output logic [decode_pkg::ADDR_W-1:0]         eip_out,
    output logic [decode_pkg::ADDR_W-1:0]         latched_eip_out
);
    import decode_pkg::*;

    logic [LEN_W-1:0] decoded_length;  // before redirect zeroing

    prefix_if pfx_bus ();
    opcode_if opc_bus ();
    addr_if   addr_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // decode chain
    ////////////////////////////////////////////////////////////////////////////
    prefix_decode u_prefix_decode (.packet(packet_in), .pfx(pfx_bus));

    opcode_decode u_opcode_decode (.packet(packet_in), .pfx(pfx_bus), .opc(opc_bus));

    modrm_decode u_modrm_decode (.packet(packet_in), .opc(opc_bus), .addr(addr_bus));

    disp_imm_length u_disp_imm_length (
        .packet (packet_in),
        .opc    (opc_bus),
        .addr   (addr_bus),
        .disp   (disp_out),
        .imm    (imm_out),
        .length (decoded_length)
    );

    ////////////////////////////////////////////////////////////////////////////
    // instruction pointer
    ////////////////////////////////////////////////////////////////////////////
    eip_control u_eip_control (
        .clk              (clk),
        .rst_n            (rst_n),
        .valid_in         (valid_in),
        .queue_full_stall (queue_full_stall),
        .is_init          (is_init),
        .is_resteer       (is_resteer),
        .is_br_taken      (is_br_taken),
        .init_eip         (init_eip),
        .wb_eip           (wb_eip),
        .bp_eip           (bp_eip),
        .decoded_length   (decoded_length),
        .d_length         (d_length),
        .latched_eip      (latched_eip_out),
        .eip_next         (eip_out)
    );

    // level pass through, no handshake
    assign valid_out      = valid_in;
    assign stall_out      = queue_full_stall;
    assign rep_out        = pfx_bus.rep;
    assign opsize_ovr_out = pfx_bus.opsize_ovr;
    assign seg_valid_out  = pfx_bus.seg_valid;
    assign seg_sel_out    = pfx_bus.seg_sel;
    assign is_br_out      = opc_bus.is_br;
    assign reg_field_out  = addr_bus.reg_field;
    assign base_reg_out   = addr_bus.base_reg;
    assign index_reg_out  = addr_bus.index_reg;
    assign scale_out      = addr_bus.scale;
    assign use_base_out   = addr_bus.use_base;
    assign use_index_out  = addr_bus.use_index;

endmodule

`default_nettype wire

// ==== src/eip_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module eip_control (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          valid_in,
    input  logic                          queue_full_stall,
    input  logic                          is_init,
    input  logic                          is_resteer,
    input  logic                          is_br_taken,
    input  logic [decode_pkg::ADDR_W-1:0] init_eip,
    input  logic [decode_pkg::ADDR_W-1:0] wb_eip,
    input  logic [decode_pkg::ADDR_W-1:0] bp_eip,
    input  logic [decode_pkg::LEN_W-1:0]  decoded_length,
    output logic [decode_pkg::LEN_W-1:0]  d_length,
    output logic [decode_pkg::ADDR_W-1:0] latched_eip,
    output logic [decode_pkg::ADDR_W-1:0] eip_next
);
    import decode_pkg::*;

    logic              is_cf;   // any redirect this cycle
    logic              ld_eip;
    logic [ADDR_W-1:0] cf_eip;

    assign is_cf  = is_init | is_resteer | is_br_taken;
    assign cf_eip = is_init    ? init_eip :  // init beats writeback beats bp
                    is_resteer ? wb_eip   : bp_eip;

    assign d_length = is_cf ? '0 : decoded_length;
    assign eip_next = latched_eip + ADDR_W'(d_length);

    // redirect loads even while the queue is full
    assign ld_eip = (valid_in & ~queue_full_stall) | is_cf;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            latched_eip <= '0;
        end else if (ld_eip) begin
            latched_eip <= is_cf ? cf_eip : eip_next;
        end
    end

endmodule

`default_nettype wire

// ==== src/disp_imm_length.sv ====
`timescale 1ns/1ps
`default_nettype none

module disp_imm_length (
    input  logic [decode_pkg::PACKET_BYTES*8-1:0] packet,
    opcode_if.len                                 opc,
    addr_if.len                                   addr,
    output logic [decode_pkg::ADDR_W-1:0]         disp,
    output logic [decode_pkg::ADDR_W-1:0]         imm,
    output logic [decode_pkg::LEN_W-1:0]          length
);
    import decode_pkg::*;

    logic [POS_W-1:0] disp_pos;  // after modrm and sib
    logic [POS_W-1:0] imm_pos;   // after the displacement, also the body end

    // little endian field, sign extended from its own size
    function automatic logic [ADDR_W-1:0] read_le(input logic [PACKET_BYTES*8-1:0] pkt,
                                                  input logic [POS_W-1:0] pos,
                                                  input logic [2:0] size);
        logic [ADDR_W-1:0] raw;
        raw = {pkt_byte(pkt, pos + POS_W'(3)), pkt_byte(pkt, pos + POS_W'(2)),
               pkt_byte(pkt, pos + POS_W'(1)), pkt_byte(pkt, pos)};
        case (size)
            3'd1:    return {{24{raw[7]}}, raw[7:0]};
            3'd2:    return {{16{raw[15]}}, raw[15:0]};
            3'd4:    return raw;
            default: return '0; // field absent
        endcase
    endfunction

    assign disp_pos = opc.body_pos + POS_W'(opc.has_modrm) + POS_W'(addr.has_sib);
    assign imm_pos  = disp_pos + POS_W'(addr.disp_size);

    assign disp = read_le(packet, disp_pos, addr.disp_size);
    assign imm  = read_le(packet, imm_pos, opc.imm_size);

    // prefixes + opcode + modrm + sib + disp + imm
    assign length = LEN_W'(imm_pos) + LEN_W'(opc.imm_size);

endmodule

`default_nettype wire

// ==== src/modrm_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module modrm_decode (
    input  logic [decode_pkg::PACKET_BYTES*8-1:0] packet,
    opcode_if.addr                                opc,
    addr_if.drv                                   addr
);
    import decode_pkg::*;

    modrm_sib_u modrm;
    modrm_sib_u sib;

    assign modrm = pkt_byte(packet, opc.body_pos);
    assign sib   = pkt_byte(packet, opc.body_pos + POS_W'(1));

    ////////////////////////////////////////////////////////////////////////////
    // 32 bit addressing forms
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        addr.reg_field = '0;
        addr.base_reg  = '0;
        addr.index_reg = '0;
        addr.scale     = 2'd0;
        addr.use_base  = 1'b0;
        addr.use_index = 1'b0;
        addr.has_sib   = 1'b0;
        addr.disp_size = 3'd0;
        if (opc.has_modrm) begin
            addr.reg_field = modrm.modrm.reg_op;
            if (modrm.modrm.mod == 2'b11) begin
                addr.base_reg = modrm.modrm.rm;    // register direct
                addr.use_base = 1'b1;
            end else begin
                case (modrm.modrm.mod)
                    2'b01:   addr.disp_size = 3'd1;
                    2'b10:   addr.disp_size = 3'd4;
                    default: addr.disp_size = 3'd0;
                endcase
                if (modrm.modrm.rm == 3'b100) begin
                    addr.has_sib = 1'b1;
                    addr.scale   = sib.sib.scale;
                    if (sib.sib.index != 3'b100) begin // 100 means no index
                        addr.index_reg = sib.sib.index;
                        addr.use_index = 1'b1;
                    end
                    if (sib.sib.base == 3'b101 && modrm.modrm.mod == 2'b00) begin
                        addr.disp_size = 3'd4;         // no base, disp32
                    end else begin
                        addr.base_reg = sib.sib.base;
                        addr.use_base = 1'b1;
                    end
                end else if (modrm.modrm.mod == 2'b00 && modrm.modrm.rm == 3'b101) begin
                    addr.disp_size = 3'd4;             // absolute disp32
                end else begin
                    addr.base_reg = modrm.modrm.rm;
                    addr.use_base = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/opcode_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module opcode_decode (
    input  logic [decode_pkg::PACKET_BYTES*8-1:0] packet,
    prefix_if.opc                                 pfx,
    opcode_if.drv                                 opc
);
    import decode_pkg::*;

    logic [POS_W-1:0] op_pos;
    logic [7:0]       op0;   // primary opcode
    logic [7:0]       op1;   // second byte after 0F
    logic [2:0]       imm_z; // 4, or 2 under 66

    assign op_pos = POS_W'(pfx.num_prefixes);
    assign op0    = pkt_byte(packet, op_pos);
    assign op1    = pkt_byte(packet, op_pos + POS_W'(1));
    assign imm_z  = pfx.opsize_ovr ? 3'd2 : 3'd4;

    ////////////////////////////////////////////////////////////////////////////
    // opcode table
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        opc.has_modrm = 1'b0;
        opc.imm_size  = 3'd0;
        opc.is_br     = 1'b0;
        opc.body_pos  = op_pos + POS_W'(1);
        if (op0 == OPC_ESCAPE) begin
            opc.body_pos = op_pos + POS_W'(2);      // two byte opcode
            if (op1[7:4] == OPC_JCC_REL[7:4]) begin // jcc rel32
                opc.imm_size = imm_z;
                opc.is_br    = 1'b1;
            end else if (op1 == OPC_IMUL_RM) begin
                opc.has_modrm = 1'b1;
            end
        end else begin
            case (op0)
                OPC_ADD_MR, OPC_ADD_RM, OPC_MOV_MR, OPC_MOV_RM: begin
                    opc.has_modrm = 1'b1;
                end
                OPC_ADD_EAX: opc.imm_size = imm_z;
                OPC_GRP1_IZ: begin
                    opc.has_modrm = 1'b1;
                    opc.imm_size  = imm_z;
                end
                OPC_GRP1_IB: begin
                    opc.has_modrm = 1'b1;
                    opc.imm_size  = 3'd1;
                end
                OPC_JMP_REL8: begin
                    opc.imm_size = 3'd1;
                    opc.is_br    = 1'b1;
                end
                OPC_JMP_REL32: begin
                    opc.imm_size = imm_z;
                    opc.is_br    = 1'b1;
                end
                OPC_NOP, OPC_RET: opc.imm_size = 3'd0; // single byte
                default: begin
                    if (op0[7:3] == OPC_MOV_RI[7:3]) begin // mov r32, imm
                        opc.imm_size = imm_z;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/prefix_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefix_decode (
    input  logic [decode_pkg::PACKET_BYTES*8-1:0] packet,
    prefix_if.drv                                 pfx
);
    import decode_pkg::*;

    logic       rep;
    logic       opsize;
    logic       seg_valid;
    logic [2:0] seg_sel;
    logic [1:0] cnt;

    // walk the leading bytes, stop at the first non prefix
    always_comb begin
        logic [7:0] b;
        logic       stop;
        rep       = 1'b0;
        opsize    = 1'b0;
        seg_valid = 1'b0;
        seg_sel   = 3'd0;
        cnt       = 2'd0;
        stop      = 1'b0;
        for (int i = 0; i < MAX_PREFIXES; i++) begin
            b = pkt_byte(packet, POS_W'(i));
            if (!stop) begin
                case (b)
                    PFX_REP:    rep = 1'b1;
                    PFX_OPSIZE: opsize = 1'b1;
                    PFX_ES:     begin seg_valid = 1'b1; seg_sel = 3'd0; end
                    PFX_CS:     begin seg_valid = 1'b1; seg_sel = 3'd1; end
                    PFX_SS:     begin seg_valid = 1'b1; seg_sel = 3'd2; end
                    PFX_DS:     begin seg_valid = 1'b1; seg_sel = 3'd3; end
                    PFX_FS:     begin seg_valid = 1'b1; seg_sel = 3'd4; end
                    PFX_GS:     begin seg_valid = 1'b1; seg_sel = 3'd5; end
                    default:    stop = 1'b1;  // opcode reached
                endcase
                if (!stop) begin
                    cnt = cnt + 2'd1;
                end
            end
        end
    end

    assign pfx.rep          = rep;
    assign pfx.opsize_ovr   = opsize;
    assign pfx.seg_valid    = seg_valid;
    assign pfx.seg_sel      = seg_sel;      // later segment prefix overwrote earlier
    assign pfx.num_prefixes = cnt;

endmodule

`default_nettype wire

// ==== src/decode_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface prefix_if;
    import decode_pkg::*;
    logic       rep;
    logic       opsize_ovr;
    logic       seg_valid;
    logic [2:0] seg_sel;       // ES..GS as 0..5
    logic [1:0] num_prefixes;  // 0..3

    modport drv (output rep, opsize_ovr, seg_valid, seg_sel, num_prefixes);
    modport opc (input num_prefixes, opsize_ovr);
endinterface

interface opcode_if;
    import decode_pkg::*;
    logic             has_modrm;
    logic [2:0]       imm_size;  // bytes, 0/1/2/4
    logic             is_br;
    logic [POS_W-1:0] body_pos;  // first byte after the opcode

    modport drv  (output has_modrm, imm_size, is_br, body_pos);
    modport addr (input has_modrm, body_pos);
    modport len  (input has_modrm, imm_size, body_pos);
endinterface

interface addr_if;
    import decode_pkg::*;
    logic [REG_W-1:0] reg_field;
    logic [REG_W-1:0] base_reg;
    logic [REG_W-1:0] index_reg;
    logic [1:0]       scale;
    logic             use_base;
    logic             use_index;
    logic             has_sib;
    logic [2:0]       disp_size;  // bytes, 0/1/4

    modport drv (output reg_field, base_reg, index_reg, scale, use_base, use_index,
                 has_sib, disp_size);
    modport len (input has_sib, disp_size);
endinterface

`default_nettype wire

// ==== src/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int PACKET_BYTES = 16;            // one fetch packet
    localparam int POS_W        = 4;             // byte index inside the packet
    localparam int ADDR_W       = 32;
    localparam int LEN_W        = 8;
    localparam int MAX_PREFIXES = 3;
    localparam int REG_W        = 3;

    // prefix bytes
    localparam logic [7:0] PFX_REP    = 8'hF3;
    localparam logic [7:0] PFX_OPSIZE = 8'h66;
    localparam logic [7:0] PFX_ES     = 8'h26;
    localparam logic [7:0] PFX_CS     = 8'h2E;
    localparam logic [7:0] PFX_SS     = 8'h36;
    localparam logic [7:0] PFX_DS     = 8'h3E;
    localparam logic [7:0] PFX_FS     = 8'h64;
    localparam logic [7:0] PFX_GS     = 8'h65;

    // opcode bytes known to the decoder
    localparam logic [7:0] OPC_ESCAPE    = 8'h0F;
    localparam logic [7:0] OPC_ADD_MR    = 8'h01;
    localparam logic [7:0] OPC_ADD_RM    = 8'h03;
    localparam logic [7:0] OPC_ADD_EAX   = 8'h05;
    localparam logic [7:0] OPC_GRP1_IZ   = 8'h81;
    localparam logic [7:0] OPC_GRP1_IB   = 8'h83;
    localparam logic [7:0] OPC_MOV_MR    = 8'h89;
    localparam logic [7:0] OPC_MOV_RM    = 8'h8B;
    localparam logic [7:0] OPC_NOP       = 8'h90;
    localparam logic [7:0] OPC_MOV_RI    = 8'hB8;  // B8..BF, reg in low bits
    localparam logic [7:0] OPC_RET       = 8'hC3;
    localparam logic [7:0] OPC_JMP_REL32 = 8'hE9;
    localparam logic [7:0] OPC_JMP_REL8  = 8'hEB;
    localparam logic [7:0] OPC_JCC_REL   = 8'h80;  // 0F 80..8F
    localparam logic [7:0] OPC_IMUL_RM   = 8'hAF;  // 0F AF

    // same byte seen as modrm or as sib
    typedef union packed {
        struct packed {
            logic [1:0] mod;
            logic [2:0] reg_op;
            logic [2:0] rm;
        } modrm;
        struct packed {
            logic [1:0] scale;
            logic [2:0] index;
            logic [2:0] base;
        } sib;
    } modrm_sib_u;

    // byte 0 sits in the top bits of the packet
    function automatic logic [7:0] pkt_byte(input logic [PACKET_BYTES*8-1:0] pkt,
                                            input logic [POS_W-1:0] idx);
        return pkt[(PACKET_BYTES - 1 - int'(idx))*8 +: 8];
    endfunction

endpackage

`default_nettype wire
